// File: files.f
logic/isa_pkg.sv
logic/core_pkg.sv
logic/branch_decoder.sv
logic/reg_file.sv
logic/next_pc.sv
logic/pc_sequencer.sv
logic/flow_top.sv
dv/flow_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the flow_tb simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module flow_tb -f files.f -o flow_sim \
    && ./obj_dir/flow_sim \
    || { echo "simulation did not pass"; exit 1; }

// File: dv/flow_tb.sv
`timescale 1ns/1ps

module flow_tb;

    localparam int IMEM_WORDS  = 1024;
    localparam int MAX_ENTRIES = 64;

    logic              clk;
    logic              rst_n;
    logic              stall;
    logic              ext_we;
    isa_pkg::reg_idx_t ext_addr;
    isa_pkg::word_t    ext_data;
    isa_pkg::word_t    instr;
    isa_pkg::word_t    pc;
    logic              retire;
    logic              link_we;
    isa_pkg::reg_idx_t link_addr;
    isa_pkg::word_t    link_data;

    isa_pkg::word_t imem [IMEM_WORDS];

    // One row per instruction with stimulus and expected results.
    isa_pkg::word_t    tbl_instr     [MAX_ENTRIES];
    isa_pkg::reg_idx_t tbl_a_idx     [MAX_ENTRIES];
    isa_pkg::word_t    tbl_a_val     [MAX_ENTRIES];
    isa_pkg::reg_idx_t tbl_b_idx     [MAX_ENTRIES];
    isa_pkg::word_t    tbl_b_val     [MAX_ENTRIES];
    int                tbl_stalls    [MAX_ENTRIES];
    isa_pkg::reg_idx_t tbl_clash_idx [MAX_ENTRIES];
    isa_pkg::word_t    tbl_clash_val [MAX_ENTRIES];
    isa_pkg::word_t    tbl_exp_pc    [MAX_ENTRIES];
    logic              tbl_exp_we    [MAX_ENTRIES];
    isa_pkg::reg_idx_t tbl_exp_addr  [MAX_ENTRIES];
    isa_pkg::word_t    tbl_exp_data  [MAX_ENTRIES];

    int n_entries   = 0;
    int max_stall   = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;

    // Reference state advanced while the table is built.
    isa_pkg::word_t model_pc;
    isa_pkg::word_t model_regs [32];
    isa_pkg::word_t lcg_state = 32'd95;

    flow_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .stall     (stall),
        .ext_we    (ext_we),
        .ext_addr  (ext_addr),
        .ext_data  (ext_data),
        .pc        (pc),
        .retire    (retire),
        .link_we   (link_we),
        .link_addr (link_addr),
        .link_data (link_data)
    );

    assign instr = imem[pc[11:2]];  // Combinational fetch.

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] tgt);
        return {op, tgt};
    endfunction

    function automatic logic [31:0] enc_r(input int rs, input int rd, input logic [5:0] fn);
        return {isa_pkg::OP_SPECIAL, rs[4:0], 5'd0, rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] reg_val(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'd0 : model_regs[idx];
    endfunction

    // Next pc and link write from the ISA rules.
    task automatic predict(input logic [31:0] word, input logic [31:0] cur_pc,
                           output logic [31:0] nxt, output logic lwe,
                           output logic [4:0] laddr, output logic [31:0] ldata);
        logic [31:0] pc4;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] br;
        logic        link;
        logic [4:0]  dest;
        pc4  = cur_pc + core_pkg::PC_STEP;
        rs   = reg_val(word[25:21]);
        rt   = reg_val(word[20:16]);
        br   = pc4 + {{14{word[15]}}, word[15:0], 2'b00};
        nxt  = pc4;
        link = 1'b0;
        dest = core_pkg::LINK_REG;
        case (word[31:26])
            isa_pkg::OP_SPECIAL: begin
                if (word[5:0] == isa_pkg::FN_JR) begin
                    nxt = rs;
                end else if (word[5:0] == isa_pkg::FN_JALR) begin
                    nxt  = rs;
                    link = 1'b1;
                    dest = word[15:11];
                end
            end
            isa_pkg::OP_REGIMM: begin
                if (word[20:16] == isa_pkg::RT_BLTZ || word[20:16] == isa_pkg::RT_BLTZAL) begin
                    if ($signed(rs) < 0) nxt = br;
                end else if (word[20:16] == isa_pkg::RT_BGEZ
                             || word[20:16] == isa_pkg::RT_BGEZAL) begin
                    if ($signed(rs) >= 0) nxt = br;
                end
                link = (word[20:16] == isa_pkg::RT_BLTZAL) || (word[20:16] == isa_pkg::RT_BGEZAL);
            end
            isa_pkg::OP_J:    nxt = {pc4[31:28], word[25:0], 2'b00};
            isa_pkg::OP_JAL: begin
                nxt  = {pc4[31:28], word[25:0], 2'b00};
                link = 1'b1;
            end
            isa_pkg::OP_BEQ:  if (rs == rt) nxt = br;
            isa_pkg::OP_BNE:  if (rs != rt) nxt = br;
            isa_pkg::OP_BLEZ: if ($signed(rs) <= 0) nxt = br;
            isa_pkg::OP_BGTZ: if ($signed(rs) > 0) nxt = br;
            default: ;
        endcase
        lwe   = link && (dest != 5'd0);
        laddr = lwe ? dest : 5'd0;
        ldata = pc4;
    endtask

    task automatic add_entry(input logic [31:0] word, input int a_idx, input logic [31:0] a_val,
                             input int b_idx, input logic [31:0] b_val, input int stalls,
                             input int clash_idx, input logic [31:0] clash_val);
        logic [31:0] nxt;
        logic        lwe;
        logic [4:0]  laddr;
        logic [31:0] ldata;
        int          k;
        k = n_entries;
        tbl_instr[k]     = word;
        tbl_a_idx[k]     = a_idx[4:0];
        tbl_a_val[k]     = a_val;
        tbl_b_idx[k]     = b_idx[4:0];
        tbl_b_val[k]     = b_val;
        tbl_stalls[k]    = stalls;
        tbl_clash_idx[k] = clash_idx[4:0];
        tbl_clash_val[k] = clash_val;
        if (a_idx[4:0] != 5'd0) model_regs[a_idx[4:0]] = a_val;
        if (b_idx[4:0] != 5'd0) model_regs[b_idx[4:0]] = b_val;
        predict(word, model_pc, nxt, lwe, laddr, ldata);
        tbl_exp_pc[k]   = nxt;
        tbl_exp_we[k]   = lwe;
        tbl_exp_addr[k] = laddr;
        tbl_exp_data[k] = ldata;
        // Link write beats the external write in the same cycle.
        if (lwe) begin
            model_regs[laddr] = ldata;
        end else if (clash_idx[4:0] != 5'd0) begin
            model_regs[clash_idx[4:0]] = clash_val;
        end
        model_pc  = nxt;
        n_entries = n_entries + 1;
        if (stalls > max_stall) max_stall = stalls;
    endtask

    task automatic build_table();
        int          i;
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] off;
        logic [31:0] w;
        model_pc = core_pkg::RESET_PC;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        add_entry(32'h0000_0020, 0, 0, 0, 0, 0, 0, 0);  // Not a control-flow word.
        add_entry(enc_i(isa_pkg::OP_BEQ, 1, 2, 16'h0003), 1, 5, 2, 5, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BNE, 1, 2, 16'h0003), 1, 5, 2, 5, 1, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BEQ, 1, 2, 16'h0010), 1, 32'hFFFF_FFFF,
                  2, 32'h7FFF_FFFF, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BNE, 1, 2, 16'hFFF0), 1, 0, 2, 32'h8000_0000, 2, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BLEZ, 1, 0, 16'h0020), 1, 0, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BLEZ, 1, 0, 16'hFF00), 1, 32'hFFFF_FFFF, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BLEZ, 1, 0, 16'h0020), 1, 1, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BGTZ, 1, 0, 16'h0044), 1, 0, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BGTZ, 1, 0, 16'h0044), 1, 1, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_BGTZ, 1, 0, 16'h0044), 1, 32'h8000_0000, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BLTZ, 16'hFFFE), 1,
                  32'h8000_0000, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BLTZ, 16'h0100), 1, 0, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BGEZ, 16'h0100), 1, 0, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BGEZ, 16'h0100), 1,
                  32'hFFFF_FFFF, 0, 0, 0, 0, 0);
        // Random operands with every third pair equal.
        for (i = 0; i < 12; i++) begin
            ra  = lcg_next();
            rb  = (i % 3 == 0) ? ra : lcg_next();
            off = lcg_next() >> 16;
            case (i % 6)
                0:       w = enc_i(isa_pkg::OP_BEQ, 1, 2, off[15:0]);
                1:       w = enc_i(isa_pkg::OP_BNE, 1, 2, off[15:0]);
                2:       w = enc_i(isa_pkg::OP_BLEZ, 1, 0, off[15:0]);
                3:       w = enc_i(isa_pkg::OP_BGTZ, 1, 0, off[15:0]);
                4:       w = enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BLTZ, off[15:0]);
                default: w = enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BGEZ, off[15:0]);
            endcase
            add_entry(w, 1, ra, 2, rb, i % 4, 0, 0);
        end
        // Region jumps and the r31 return path.
        add_entry(enc_r(8, 0, isa_pkg::FN_JR), 8, 32'h3000_0100, 0, 0, 0, 0, 0);
        add_entry(enc_j(isa_pkg::OP_J, 26'h012_3456), 0, 0, 0, 0, 3, 0, 0);
        add_entry(enc_j(isa_pkg::OP_JAL, 26'h000_0400), 0, 0, 0, 0, 0, 0, 0);
        add_entry(enc_r(31, 0, isa_pkg::FN_JR), 0, 0, 0, 0, 0, 0, 0);
        add_entry(enc_r(8, 5, isa_pkg::FN_JALR), 8, 32'h0000_0A40, 0, 0, 1, 0, 0);
        add_entry(enc_r(5, 0, isa_pkg::FN_JR), 0, 0, 0, 0, 0, 0, 0);
        add_entry(enc_r(8, 0, isa_pkg::FN_JALR), 8, 32'h0000_2000, 0, 0, 0, 0, 0);
        // Linking branches racing an external write to r31.
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BLTZAL, 16'h0040), 1,
                  32'hFFFF_FF00, 0, 0, 0, 31, 32'hDEAD_BEE0);
        add_entry(enc_r(31, 0, isa_pkg::FN_JR), 0, 0, 0, 0, 1, 0, 0);
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BGEZAL, 16'h0040), 1,
                  32'h8000_0004, 0, 0, 2, 31, 32'h0BAD_F00C);
        add_entry(enc_r(31, 0, isa_pkg::FN_JR), 0, 0, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BGEZAL, 16'h0010), 1, 0, 0, 0, 7, 0, 0);
        add_entry(enc_r(31, 0, isa_pkg::FN_JR), 0, 0, 0, 0, 0, 0, 0);
        add_entry(enc_i(isa_pkg::OP_REGIMM, 1, isa_pkg::RT_BLTZAL, 16'h0010), 1, 5, 0, 0, 0, 0, 0);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got == want) else begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, want);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic run_entry(input int k);
        int          waited;
        logic [31:0] start_pc;
        start_pc = pc;
        imem[start_pc[11:2]] = tbl_instr[k];
        stall    = 1'b1;  // Held through both preloads.
        ext_we   = 1'b1;
        ext_addr = tbl_a_idx[k];
        ext_data = tbl_a_val[k];
        waited   = 0;
        while (!retire) begin
            @(posedge clk);
            #5;
            waited++;
            if (waited == 1) begin
                ext_addr = tbl_b_idx[k];
                ext_data = tbl_b_val[k];
            end else begin
                ext_we = 1'b0;
            end
            stall = (waited < 2 + tbl_stalls[k]);
            if (!retire) begin
                check_word("pc", pc, start_pc);
                check_word("link_we", {31'd0, link_we}, 32'd0);
            end
        end
        check_word("retire cycles", waited, 3 + tbl_stalls[k]);
        check_word("pc", pc, start_pc);
        check_word("link_we", {31'd0, link_we}, {31'd0, tbl_exp_we[k]});
        if (tbl_exp_we[k]) begin
            check_word("link_addr", {27'd0, link_addr}, {27'd0, tbl_exp_addr[k]});
            check_word("link_data", link_data, tbl_exp_data[k]);
        end
        stall    = (tbl_stalls[k] != 0);  // Must not hold up EXEC.
        ext_we   = (tbl_clash_idx[k] != 5'd0);
        ext_addr = tbl_clash_idx[k];
        ext_data = tbl_clash_val[k];
        @(posedge clk);
        #5;
        ext_we = 1'b0;
        check_word("pc", pc, tbl_exp_pc[k]);
        check_word("retire", {31'd0, retire}, 32'd0);
    endtask

    initial begin
        int i;
        rst_n    = 1'b0;
        stall    = 1'b1;
        ext_we   = 1'b0;
        ext_addr = 5'd0;
        ext_data = 32'd0;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'hFC00_0000 | i;  // Opcode 0x3F is never control flow.
        end
        build_table();
        cycle_limit = n_entries * (6 + max_stall) + 50;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_word("pc", pc, core_pkg::RESET_PC);
        check_word("retire", {31'd0, retire}, 32'd0);
        check_word("link_we", {31'd0, link_we}, 32'd0);
        for (i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("TEST OK");
        $finish;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout waiting for retire");
        $display("TEST FAILED");
        $fatal(1, "cycle limit reached");
    end

endmodule

// File: logic/flow_top.sv
`timescale 1ns/1ps

module flow_top (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::word_t    instr,
    input  logic              stall,
    input  logic              ext_we,
    input  isa_pkg::reg_idx_t ext_addr,
    input  isa_pkg::word_t    ext_data,
    output isa_pkg::word_t    pc,
    output logic              retire,
    output logic              link_we,
    output isa_pkg::reg_idx_t link_addr,
    output isa_pkg::word_t    link_data
);

    isa_pkg::word_t     ir;
    isa_pkg::word_t     next_pc_val;
    isa_pkg::word_t     rs_val;
    isa_pkg::word_t     rt_val;
    isa_pkg::reg_idx_t  rs_idx;
    isa_pkg::reg_idx_t  rt_idx;
    isa_pkg::reg_idx_t  rd_idx;
    isa_pkg::imm16_t    imm;
    isa_pkg::target26_t target;
    logic               exec;
    logic               is_j;
    logic               is_jal;
    logic               is_jr;
    logic               is_jalr;
    logic               is_beq;
    logic               is_bne;
    logic               is_blez;
    logic               is_bgtz;
    logic               is_bltz;
    logic               is_bgez;
    logic               is_bltzal;
    logic               is_bgezal;

    assign retire = exec;

    pc_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .instr       (instr),
        .next_pc_val (next_pc_val),
        .pc          (pc),
        .ir          (ir),
        .exec        (exec)
    );

    branch_decoder u_dec (
        .ir        (ir),
        .is_j      (is_j),      .is_jal    (is_jal),
        .is_jr     (is_jr),     .is_jalr   (is_jalr),
        .is_beq    (is_beq),    .is_bne    (is_bne),
        .is_blez   (is_blez),   .is_bgtz   (is_bgtz),
        .is_bltz   (is_bltz),   .is_bgez   (is_bgez),
        .is_bltzal (is_bltzal), .is_bgezal (is_bgezal),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rd_idx    (rd_idx),
        .imm       (imm),
        .target    (target)
    );

    reg_file u_rf (
        .clk       (clk),       .rst_n     (rst_n),
        .rs_idx    (rs_idx),    .rt_idx    (rt_idx),
        .rs_val    (rs_val),    .rt_val    (rt_val),
        .link_we   (link_we),   .link_addr (link_addr), .link_data (link_data),
        .ext_we    (ext_we),    .ext_addr  (ext_addr),  .ext_data  (ext_data)
    );

    next_pc u_npc (
        .pc          (pc),        .exec      (exec),
        .is_j        (is_j),      .is_jal    (is_jal),
        .is_jr       (is_jr),     .is_jalr   (is_jalr),
        .is_beq      (is_beq),    .is_bne    (is_bne),
        .is_blez     (is_blez),   .is_bgtz   (is_bgtz),
        .is_bltz     (is_bltz),   .is_bgez   (is_bgez),
        .is_bltzal   (is_bltzal), .is_bgezal (is_bgezal),
        .rd_idx      (rd_idx),    .imm       (imm),       .target (target),
        .rs_val      (rs_val),    .rt_val    (rt_val),
        .next_pc_val (next_pc_val),
        .link_we     (link_we),
        .link_addr   (link_addr),
        .link_data   (link_data)
    );

endmodule

// File: logic/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  isa_pkg::word_t instr,
    input  isa_pkg::word_t next_pc_val,
    output isa_pkg::word_t pc,
    output isa_pkg::word_t ir,
    output logic           exec
);

    core_pkg::phase_t phase;
    logic             fetch_go;

    // A stalled fetch simply repeats.
    assign fetch_go = (phase == core_pkg::PH_FETCH) && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= core_pkg::PH_FETCH;
            pc    <= core_pkg::RESET_PC;
        end else begin
            case (phase)
                core_pkg::PH_FETCH: begin
                    if (!stall) begin
                        phase <= core_pkg::PH_EXEC;
                    end
                end
                core_pkg::PH_EXEC: begin
                    // EXEC always completes and ignores stall.
                    pc    <= next_pc_val;
                    phase <= core_pkg::PH_FETCH;
                end
                default: phase <= core_pkg::PH_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            ir <= instr;  // Held through EXEC.
        end
    end

    assign exec = (phase == core_pkg::PH_EXEC);

endmodule

// File: logic/next_pc.sv
`timescale 1ns/1ps

module next_pc (
    input  isa_pkg::word_t     pc,
    input  logic               exec,
    input  logic               is_j,
    input  logic               is_jal,
    input  logic               is_jr,
    input  logic               is_jalr,
    input  logic               is_beq,
    input  logic               is_bne,
    input  logic               is_blez,
    input  logic               is_bgtz,
    input  logic               is_bltz,
    input  logic               is_bgez,
    input  logic               is_bltzal,
    input  logic               is_bgezal,
    input  isa_pkg::reg_idx_t  rd_idx,
    input  isa_pkg::imm16_t    imm,
    input  isa_pkg::target26_t target,
    input  isa_pkg::word_t     rs_val,
    input  isa_pkg::word_t     rt_val,
    output isa_pkg::word_t     next_pc_val,
    output logic               link_we,
    output isa_pkg::reg_idx_t  link_addr,
    output isa_pkg::word_t     link_data
);

    isa_pkg::word_t pc4;
    isa_pkg::word_t imm_ext;
    isa_pkg::word_t br_target;
    isa_pkg::word_t j_target;
    logic           rs_neg;
    logic           rs_zero;
    logic           rs_eq_rt;
    logic           taken;
    logic           link_req;

    assign pc4 = pc + core_pkg::PC_STEP;

    assign imm_ext = {{(isa_pkg::WORD_W - isa_pkg::IMM_W){imm[isa_pkg::IMM_W-1]}}, imm};

    // Branch offset counts words from the following instruction.
    assign br_target = pc4 + (imm_ext << 2);

    // Region jump keeps the top nibble of pc4.
    assign j_target = {pc4[31:28], target, 2'b00};

    // Signed tests only need the sign bit and a zero flag.
    assign rs_neg   = rs_val[isa_pkg::WORD_W-1];
    assign rs_zero  = (rs_val == '0);
    assign rs_eq_rt = (rs_val == rt_val);

    assign taken = (is_beq & rs_eq_rt)
                 | (is_bne & ~rs_eq_rt)
                 | (is_blez & (rs_neg | rs_zero))
                 | (is_bgtz & ~rs_neg & ~rs_zero)
                 | ((is_bltz | is_bltzal) & rs_neg)
                 | ((is_bgez | is_bgezal) & ~rs_neg);

    always_comb begin
        if (is_jr || is_jalr) begin
            next_pc_val = rs_val;
        end else if (is_j || is_jal) begin
            next_pc_val = j_target;
        end else if (taken) begin
            next_pc_val = br_target;
        end else begin
            next_pc_val = pc4;  // Fall through.
        end
    end

    // Linking branches write r31 taken or not.
    assign link_req  = is_jal | is_jalr | is_bltzal | is_bgezal;
    assign link_addr = is_jalr ? rd_idx : core_pkg::LINK_REG;
    assign link_data = pc4;
    assign link_we   = exec & link_req & (link_addr != '0);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rs_idx,
    input  isa_pkg::reg_idx_t rt_idx,
    output isa_pkg::word_t    rs_val,
    output isa_pkg::word_t    rt_val,
    input  logic              link_we,
    input  isa_pkg::reg_idx_t link_addr,
    input  isa_pkg::word_t    link_data,
    input  logic              ext_we,
    input  isa_pkg::reg_idx_t ext_addr,
    input  isa_pkg::word_t    ext_data
);

    isa_pkg::word_t    regs [isa_pkg::NUM_REGS];
    logic              wr_en;
    isa_pkg::reg_idx_t wr_addr;
    isa_pkg::word_t    wr_data;

    // One write port. The link write wins over the external one.
    always_comb begin
        if (link_we) begin
            wr_en   = 1'b1;
            wr_addr = link_addr;
            wr_data = link_data;
        end else begin
            wr_en   = ext_we;
            wr_addr = ext_addr;
            wr_data = ext_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];  // r0 is hardwired.
    assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

// File: logic/branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder (
    input  isa_pkg::word_t     ir,
    output logic               is_j,
    output logic               is_jal,
    output logic               is_jr,
    output logic               is_jalr,
    output logic               is_beq,
    output logic               is_bne,
    output logic               is_blez,
    output logic               is_bgtz,
    output logic               is_bltz,
    output logic               is_bgez,
    output logic               is_bltzal,
    output logic               is_bgezal,
    output isa_pkg::reg_idx_t  rs_idx,
    output isa_pkg::reg_idx_t  rt_idx,
    output isa_pkg::reg_idx_t  rd_idx,
    output isa_pkg::imm16_t    imm,
    output isa_pkg::target26_t target
);

    logic [isa_pkg::OP_W-1:0] opcode;
    logic [isa_pkg::FN_W-1:0] funct;

    assign opcode = ir[31:26];
    assign funct  = ir[5:0];

    assign rs_idx = ir[25:21];
    assign rt_idx = ir[20:16];
    assign rd_idx = ir[15:11];
    assign imm    = ir[15:0];
    assign target = ir[25:0];

    always_comb begin
        is_j      = 1'b0;
        is_jal    = 1'b0;
        is_jr     = 1'b0;
        is_jalr   = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_blez   = 1'b0;
        is_bgtz   = 1'b0;
        is_bltz   = 1'b0;
        is_bgez   = 1'b0;
        is_bltzal = 1'b0;
        is_bgezal = 1'b0;

        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                // Only the register jumps are of interest here.
                case (funct)
                    isa_pkg::FN_JR:   is_jr   = 1'b1;
                    isa_pkg::FN_JALR: is_jalr = 1'b1;
                    default: ;
                endcase
            end
            isa_pkg::OP_REGIMM: begin
                case (rt_idx)
                    isa_pkg::RT_BLTZ:   is_bltz   = 1'b1;
                    isa_pkg::RT_BGEZ:   is_bgez   = 1'b1;
                    isa_pkg::RT_BLTZAL: is_bltzal = 1'b1;
                    isa_pkg::RT_BGEZAL: is_bgezal = 1'b1;
                    default: ;
                endcase
            end
            isa_pkg::OP_J:    is_j    = 1'b1;
            isa_pkg::OP_JAL:  is_jal  = 1'b1;
            isa_pkg::OP_BEQ:  is_beq  = 1'b1;
            isa_pkg::OP_BNE:  is_bne  = 1'b1;
            isa_pkg::OP_BLEZ: is_blez = 1'b1;
            isa_pkg::OP_BGTZ: is_bgtz = 1'b1;
            default: ;  // Not a control-flow word.
        endcase
    end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

    // Two-phase sequencing with one instruction in flight.
    typedef enum logic {
        PH_FETCH,
        PH_EXEC
    } phase_t;

    localparam isa_pkg::word_t RESET_PC = 32'h0000_0000;

    // Return address register for JAL and the linking branches.
    localparam isa_pkg::reg_idx_t LINK_REG = 5'd31;

    localparam isa_pkg::word_t PC_STEP = 32'd4;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

    // Field widths of the 32-bit instruction word.
    localparam int WORD_W = 32;
    localparam int OP_W   = 6;
    localparam int FN_W   = 6;
    localparam int REG_W  = 5;
    localparam int IMM_W  = 16;
    localparam int TGT_W  = 26;

    localparam int NUM_REGS = 2 ** REG_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IMM_W-1:0]  imm16_t;
    typedef logic [TGT_W-1:0]  target26_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    // Primary opcodes in ir[31:26].
    localparam logic [OP_W-1:0] OP_SPECIAL = 6'b000000;
    localparam logic [OP_W-1:0] OP_REGIMM  = 6'b000001;
    localparam logic [OP_W-1:0] OP_J       = 6'b000010;
    localparam logic [OP_W-1:0] OP_JAL     = 6'b000011;
    localparam logic [OP_W-1:0] OP_BEQ     = 6'b000100;
    localparam logic [OP_W-1:0] OP_BNE     = 6'b000101;
    localparam logic [OP_W-1:0] OP_BLEZ    = 6'b000110;
    localparam logic [OP_W-1:0] OP_BGTZ    = 6'b000111;

    // SPECIAL funct codes in ir[5:0].
    localparam logic [FN_W-1:0] FN_JR   = 6'b001000;
    localparam logic [FN_W-1:0] FN_JALR = 6'b001001;

    // REGIMM sub-opcodes carried in the rt field.
    localparam logic [REG_W-1:0] RT_BLTZ   = 5'b00000;
    localparam logic [REG_W-1:0] RT_BGEZ   = 5'b00001;
    localparam logic [REG_W-1:0] RT_BLTZAL = 5'b10000;
    localparam logic [REG_W-1:0] RT_BGEZAL = 5'b10001;

endpackage
